/* compile.f */
hdl/rd_cred_pkg.sv
hdl/rd_req_queue.sv
hdl/rd_req_parser.sv
hdl/rd_credit_gate.sv
hdl/rd_data_tagger.sv
hdl/rd_data_fifo.sv
hdl/rd_credits_top.sv
testbench/rd_credits_assert.sv
testbench/rd_credits_tb.sv

/* testbench/rd_credits_tb.sv */
`timescale 1ns/10ps

module rd_credits_tb
  import rd_cred_pkg::*;
;
  localparam int PMTU     = 64;
  localparam int CRED_MAX = 16;
  localparam int N_ROWS   = 9;

  typedef struct packed {
    logic [ADDR_W-1:0] vaddr;
    logic [LEN_W-1:0]  len;
    logic [TID_W-1:0]  tid;
    logic              hold;
    logic [2:0]        test;
  } row_t;
  typedef struct packed {
    logic [ADDR_W-1:0] vaddr;
    logic [LEN_W-1:0]  len;
    logic [TID_W-1:0]  tid;
  } req_t;
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [TID_W-1:0]  tid;
    logic              last;
  } beat_t;

  logic aclk, rst_n, s_req_valid, s_req_ready, m_req_valid, m_req_ready;
  logic [ADDR_W-1:0] s_req_vaddr, m_req_vaddr;
  logic [LEN_W-1:0]  s_req_len, m_req_len;
  logic [TID_W-1:0]  s_req_tid, m_req_tid, m_axis_tid;
  logic              card_valid, m_axis_tvalid, m_axis_tready, m_axis_tlast;
  logic [DATA_W-1:0] card_data, m_axis_tdata;

  row_t              rows [N_ROWS];
  string             names [6];
  req_t              exp_reqs [$];
  beat_t             exp_beats [$];
  logic [ADDR_W-1:0] card_q [$];
  int                errors = 0;
  int                outstanding = 0;
  int                cycles = 0;
  int                limit = 0;

  rd_credits_top #(.PMTU(PMTU), .CRED_MAX(CRED_MAX)) UUT (.*);

  always #5 aclk = ~aclk;

  // ####################
  // checks
  // ####################

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    errors++;
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic check_idle(input logic rdy, input logic req_v, input logic axis_v);
    if (rdy !== 1'b1) report_mismatch("s_req_ready", DATA_W'(rdy), 1);
    if (req_v !== 1'b0) report_mismatch("m_req_valid", DATA_W'(req_v), 0);
    if (axis_v !== 1'b0) report_mismatch("m_axis_tvalid", DATA_W'(axis_v), 0);
  endtask

  task automatic check_req(input logic [ADDR_W-1:0] vaddr, input logic [LEN_W-1:0] len,
                           input logic [TID_W-1:0] tid);
    req_t exp;
    if (exp_reqs.size() == 0) begin
      errors++;
      $display("at %0t the card got a request that no test expected", $time);
    end else begin
      exp = exp_reqs.pop_front();
      if (vaddr !== exp.vaddr) report_mismatch("m_req_vaddr", DATA_W'(vaddr), DATA_W'(exp.vaddr));
      if (len !== exp.len) report_mismatch("m_req_len", DATA_W'(len), DATA_W'(exp.len));
      if (tid !== exp.tid) report_mismatch("m_req_tid", DATA_W'(tid), DATA_W'(exp.tid));
    end
  endtask

  task automatic check_beat(input logic [DATA_W-1:0] data, input logic [TID_W-1:0] tid,
                            input logic last);
    beat_t exp;
    if (exp_beats.size() == 0) begin
      errors++;
      $display("at %0t a data beat came out that no test expected", $time);
    end else begin
      exp = exp_beats.pop_front();
      if (data !== exp.data) report_mismatch("m_axis_tdata", data, exp.data);
      if (tid !== exp.tid) report_mismatch("m_axis_tid", DATA_W'(tid), DATA_W'(exp.tid));
      if (last !== exp.last) report_mismatch("m_axis_tlast", DATA_W'(last), DATA_W'(exp.last));
    end
  endtask

  // a request is cut into PMTU pieces, the remainder goes last, and each beat's
  // data is its own byte address.
  task automatic add_expected(input row_t row);
    logic [ADDR_W-1:0] addr;
    int                rem;
    int                chunk;
    addr = row.vaddr;
    rem  = row.len;
    while (rem > 0) begin
      chunk = (rem > PMTU) ? PMTU : rem;
      exp_reqs.push_back('{addr, LEN_W'(chunk), row.tid});
      for (int b = 0; b < chunk / BEAT_BYTES; b++)
        exp_beats.push_back('{DATA_W'(addr + ADDR_W'(b * BEAT_BYTES)), row.tid,
                              b == chunk / BEAT_BYTES - 1});
      addr = addr + ADDR_W'(chunk);
      rem  = rem - chunk;
    end
  endtask

  // called one step after an edge; returns one step after the accepting edge.
  task automatic send_req(input row_t row);
    s_req_valid = 1'b1;
    s_req_vaddr = row.vaddr;
    s_req_len   = row.len;
    s_req_tid   = row.tid;
    @(posedge aclk);
    while (!s_req_ready) @(posedge aclk);
    #1 s_req_valid = 1'b0;
  endtask

  // ####################
  // card model and monitor
  // ####################

  // the card accepts requests at random and answers with a random gap per beat.
  initial begin
    void'($urandom(33));
    forever begin
      @(posedge aclk);
      #1;
      m_req_ready = ($urandom_range(0, 3) != 0);
      card_valid  = (card_q.size() != 0) && ($urandom_range(0, 2) != 0);
      if (card_valid) card_data = DATA_W'(card_q.pop_front());
    end
  end

  always @(posedge aclk) begin
    if (rst_n && m_req_valid && m_req_ready) begin
      check_req(m_req_vaddr, m_req_len, m_req_tid);
      for (int b = 0; b < int'(m_req_len) / BEAT_BYTES; b++)
        card_q.push_back(m_req_vaddr + ADDR_W'(b * BEAT_BYTES));
      outstanding += int'(m_req_len) / BEAT_BYTES;
      if (outstanding > CRED_MAX) begin
        errors++;
        $display("at %0t the card holds %0d beats, above the credit limit", $time, outstanding);
      end
    end
    if (rst_n && m_axis_tvalid && m_axis_tready) begin
      check_beat(m_axis_tdata, m_axis_tid, m_axis_tlast);
      outstanding--;
    end
  end

  // the run is cut off if the beats do not drain within the limit.
  always @(posedge aclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles with %0d beats still missing", cycles, exp_beats.size());
      $display("Finished with errors");
      $finish;
    end
  end

  // ####################
  // test sequence
  // ####################

  initial begin
    int          start_errors;
    int          failed;
    logic        hold;
    failed = 0;
    {aclk, rst_n, s_req_valid, m_req_ready, card_valid, m_axis_tready} = '0;
    {s_req_vaddr, s_req_len, s_req_tid, card_data} = '0;
    names = '{"", "reset", "short request", "long request", "queued requests", "credit stall"};
    rows[0] = '{32'h1000, 16'd32, 4'd1, 1'b0, 3'd2};
    rows[1] = '{32'h2000, 16'd200, 4'd2, 1'b0, 3'd3};
    rows[2] = '{32'h3000, 16'd64, 4'd3, 1'b0, 3'd4};
    rows[3] = '{32'h3100, 16'd16, 4'd4, 1'b0, 3'd4};
    rows[4] = '{32'h3200, 16'd96, 4'd5, 1'b0, 3'd4};
    for (int r = 5; r < N_ROWS; r++)
      rows[r] = '{32'h4000 + (r - 5) * 32'h100, 16'd64, 4'(r + 1), 1'b1, 3'd5};
    for (int r = 0; r < N_ROWS; r++) limit += rows[r].len / BEAT_BYTES;
    limit = limit * 20 + 1000;
    repeat (10) @(posedge aclk);
    #1 rst_n = 1'b1;
    check_idle(s_req_ready, m_req_valid, m_axis_tvalid);
    failed += (errors != 0);
    $display("test 1 %s: %0d errors", names[1], errors);
    for (int t = 2; t <= 5; t++) begin
      start_errors = errors;
      hold = 1'b0;
      for (int r = 0; r < N_ROWS; r++) if (rows[r].test == t) hold = rows[r].hold;
      m_axis_tready = !hold;
      for (int r = 0; r < N_ROWS; r++) begin
        if (rows[r].test == t) begin
          add_expected(rows[r]);
          send_req(rows[r]);
        end
      end
      // with the output blocked the card may only hold a full credit window.
      if (hold) begin
        repeat (40) @(posedge aclk);
        #1;
        if (outstanding != CRED_MAX) begin
          errors++;
          $display("stall held %0d beats instead of %0d", outstanding, CRED_MAX);
        end
        m_axis_tready = 1'b1;
      end
      while (exp_beats.size() != 0 || exp_reqs.size() != 0) begin
        @(posedge aclk);
        #1;
      end
      failed += (errors != start_errors);
      $display("test %0d %s: %0d errors", t, names[t], errors - start_errors);
    end
    $display("5 tests, %0d failed, %0d errors", failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* testbench/rd_credits_assert.sv */
`timescale 1ns/10ps

module rd_credits_assert
  import rd_cred_pkg::*;
#(
  parameter int CRED_MAX = 16
) (
  input logic                            aclk,
  input logic                            rst_n,
  input logic [$clog2(CRED_MAX + 1)-1:0] cnt,
  input logic                            m_req_valid,
  input logic                            m_req_ready,
  input logic [ADDR_W-1:0]               m_req_vaddr,
  input logic [LEN_W-1:0]                m_req_len,
  input logic [TID_W-1:0]                m_req_tid,
  input logic                            t_valid
);
  // both the reserved beats and the buffered beats stay inside the credit window.
  a_cnt_limit: assert property (@(posedge aclk) disable iff (!rst_n) cnt <= CRED_MAX)
    else $error("count %0d is above the credit limit %0d", cnt, CRED_MAX);

  // a stalled request keeps its valid and its values until the card takes it.
  a_req_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_req_valid && !m_req_ready |=>
      m_req_valid && $stable({m_req_vaddr, m_req_len, m_req_tid}))
    else $error("m_req changed while it was stalled");

  // a tagged card beat must always find a free slot in the buffer.
  a_no_overflow: assert property (@(posedge aclk) disable iff (!rst_n)
    t_valid |-> cnt < CRED_MAX)
    else $error("card beat arrived while the data buffer was full");

endmodule

// the gate instance checks the credit count and the issue handshake.
bind rd_credit_gate rd_credits_assert #(.CRED_MAX(CRED_MAX)) gate_checks (
  .aclk, .rst_n, .cnt(cred_cnt), .m_req_valid, .m_req_ready, .m_req_vaddr,
  .m_req_len, .m_req_tid, .t_valid(1'b0)
);

// the buffer instance checks its fill level against incoming beats.
bind rd_data_fifo rd_credits_assert #(.CRED_MAX(CRED_MAX)) buffer_checks (
  .aclk, .rst_n, .cnt(count), .m_req_valid(1'b0), .m_req_ready(1'b1),
  .m_req_vaddr('0), .m_req_len('0), .m_req_tid('0), .t_valid
);

/* hdl/rd_credits_top.sv */
`timescale 1ns/10ps

module rd_credits_top
  import rd_cred_pkg::*;
#(
  parameter int PMTU     = 64,
  parameter int CRED_MAX = 16
) (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              s_req_valid,
  output logic              s_req_ready,
  input  logic [ADDR_W-1:0] s_req_vaddr,
  input  logic [LEN_W-1:0]  s_req_len,
  input  logic [TID_W-1:0]  s_req_tid,
  output logic              m_req_valid,
  input  logic              m_req_ready,
  output logic [ADDR_W-1:0] m_req_vaddr,
  output logic [LEN_W-1:0]  m_req_len,
  output logic [TID_W-1:0]  m_req_tid,
  input  logic              card_valid,
  input  logic [DATA_W-1:0] card_data,
  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output logic [DATA_W-1:0] m_axis_tdata,
  output logic [TID_W-1:0]  m_axis_tid,
  output logic              m_axis_tlast
);
  logic               q_valid;
  logic               q_ready;
  logic [ADDR_W-1:0]  q_vaddr;
  logic [LEN_W-1:0]   q_len;
  logic [TID_W-1:0]   q_tid;
  logic               p_valid;
  logic               p_ready;
  logic [ADDR_W-1:0]  p_vaddr;
  logic [LEN_W-1:0]   p_len;
  logic [TID_W-1:0]   p_tid;
  logic [BEATS_W-1:0] p_beats;
  logic [BEATS_W-1:0] issue_beats;
  logic               issue_valid;
  logic               xfer;
  logic               t_valid;
  logic [DATA_W-1:0]  t_data;
  logic [TID_W-1:0]   t_tid;
  logic               t_last;

  // a full chunk must fit in the credit window, or it could never be issued.
  if (CRED_MAX < PMTU / BEAT_BYTES) begin : g_cfg_check
    $error("CRED_MAX is smaller than the beats of one PMTU chunk");
  end

  // a chunk is committed toward the card on the request handshake.
  assign issue_valid = m_req_valid & m_req_ready;
  // each beat that leaves the buffer frees its credit.
  assign xfer        = m_axis_tvalid & m_axis_tready;

  // ####################
  // request path
  // ####################

  rd_req_queue inst_queue (
    .aclk, .rst_n, .s_req_valid, .s_req_ready, .s_req_vaddr, .s_req_len, .s_req_tid,
    .q_valid, .q_ready, .q_vaddr, .q_len, .q_tid
  );

  rd_req_parser #(.PMTU(PMTU)) inst_parser (
    .aclk, .rst_n, .q_valid, .q_ready, .q_vaddr, .q_len, .q_tid,
    .p_valid, .p_ready, .p_vaddr, .p_len, .p_tid, .p_beats
  );

  rd_credit_gate #(.CRED_MAX(CRED_MAX)) inst_gate (
    .aclk, .rst_n, .p_valid, .p_ready, .p_vaddr, .p_len, .p_tid, .p_beats,
    .m_req_valid, .m_req_ready, .m_req_vaddr, .m_req_len, .m_req_tid,
    .issue_beats, .xfer
  );

  // ####################
  // data path
  // ####################

  rd_data_tagger #(.CRED_MAX(CRED_MAX)) inst_tagger (
    .aclk, .rst_n, .issue_valid, .issue_tid(m_req_tid), .issue_beats,
    .card_valid, .card_data, .t_valid, .t_data, .t_tid, .t_last
  );

  rd_data_fifo #(.CRED_MAX(CRED_MAX)) inst_buffer (
    .aclk, .rst_n, .t_valid, .t_data, .t_tid, .t_last,
    .m_axis_tvalid, .m_axis_tready, .m_axis_tdata, .m_axis_tid, .m_axis_tlast
  );

endmodule

/* hdl/rd_data_fifo.sv */
`timescale 1ns/10ps

module rd_data_fifo
  import rd_cred_pkg::*;
#(
  parameter int CRED_MAX = 16
) (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              t_valid,
  input  logic [DATA_W-1:0] t_data,
  input  logic [TID_W-1:0]  t_tid,
  input  logic              t_last,
  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output logic [DATA_W-1:0] m_axis_tdata,
  output logic [TID_W-1:0]  m_axis_tid,
  output logic              m_axis_tlast
);
  localparam int PTR_W = (CRED_MAX > 1) ? $clog2(CRED_MAX) : 1;
  localparam int CNT_W = $clog2(CRED_MAX + 1);

  logic [DATA_W-1:0] data_mem [CRED_MAX];
  logic [TID_W-1:0]  tid_mem [CRED_MAX];
  logic              last_mem [CRED_MAX];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              pop;

  // every beat in here was paid for by a credit, so a write always has a slot.
  assign m_axis_tvalid = (count != '0);
  assign m_axis_tdata  = data_mem[rd_ptr];
  assign m_axis_tid    = tid_mem[rd_ptr];
  assign m_axis_tlast  = last_mem[rd_ptr];
  assign pop           = m_axis_tvalid & m_axis_tready;

  always_ff @(posedge aclk) begin
    if (t_valid) begin
      data_mem[wr_ptr] <= t_data;
      tid_mem[wr_ptr]  <= t_tid;
      last_mem[wr_ptr] <= t_last;
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (t_valid) wr_ptr <= (wr_ptr == PTR_W'(CRED_MAX - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(CRED_MAX - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(t_valid) - CNT_W'(pop);
    end
  end

endmodule

/* hdl/rd_data_tagger.sv */
`timescale 1ns/10ps

module rd_data_tagger
  import rd_cred_pkg::*;
#(
  parameter int CRED_MAX = 16
) (
  input  logic               aclk,
  input  logic               rst_n,
  input  logic               issue_valid,
  input  logic [TID_W-1:0]   issue_tid,
  input  logic [BEATS_W-1:0] issue_beats,
  input  logic               card_valid,
  input  logic [DATA_W-1:0]  card_data,
  output logic               t_valid,
  output logic [DATA_W-1:0]  t_data,
  output logic [TID_W-1:0]   t_tid,
  output logic               t_last
);
  localparam int PTR_W = (CRED_MAX > 1) ? $clog2(CRED_MAX) : 1;
  localparam int CNT_W = $clog2(CRED_MAX + 1);

  // one entry per outstanding chunk, at most one per credit.
  logic [TID_W-1:0]   tid_mem [CRED_MAX];
  logic [BEATS_W-1:0] beats_mem [CRED_MAX];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  tagger_state_t      state;
  logic [BEATS_W-1:0] rem_beats;
  logic               beat_in;
  logic               beat_last;
  logic               pop;

  // a card beat always belongs to the head chunk. A beat with no chunk open is dropped.
  assign beat_in   = card_valid & (count != '0);
  // in TS_IDLE the head entry is loaded, so its full count decides last.
  assign beat_last = (state == TS_IDLE) ? (beats_mem[rd_ptr] == BEATS_W'(1))
                                        : (rem_beats == BEATS_W'(1));
  assign pop       = beat_in & beat_last;

  always_ff @(posedge aclk) begin
    if (issue_valid) begin
      tid_mem[wr_ptr]   <= issue_tid;
      beats_mem[wr_ptr] <= issue_beats;
    end
    if (beat_in) begin
      t_data <= card_data;
      t_tid  <= tid_mem[rd_ptr];
      t_last <= beat_last;
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      state     <= TS_IDLE;
      rem_beats <= '0;
      t_valid   <= 1'b0;
    end else begin
      t_valid <= beat_in;
      if (issue_valid) wr_ptr <= (wr_ptr == PTR_W'(CRED_MAX - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(CRED_MAX - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(issue_valid) - CNT_W'(pop);
      // a one-beat chunk completes in TS_IDLE and never enters TS_STREAM.
      if (beat_in) begin
        if (state == TS_IDLE) begin
          rem_beats <= beats_mem[rd_ptr] - 1'b1;
          if (!beat_last) state <= TS_STREAM;
        end else begin
          rem_beats <= rem_beats - 1'b1;
          if (beat_last) state <= TS_IDLE;
        end
      end
    end
  end

endmodule

/* hdl/rd_credit_gate.sv */
`timescale 1ns/10ps

module rd_credit_gate
  import rd_cred_pkg::*;
#(
  parameter int CRED_MAX = 16
) (
  input  logic               aclk,
  input  logic               rst_n,
  input  logic               p_valid,
  output logic               p_ready,
  input  logic [ADDR_W-1:0]  p_vaddr,
  input  logic [LEN_W-1:0]   p_len,
  input  logic [TID_W-1:0]   p_tid,
  input  logic [BEATS_W-1:0] p_beats,
  output logic               m_req_valid,
  input  logic               m_req_ready,
  output logic [ADDR_W-1:0]  m_req_vaddr,
  output logic [LEN_W-1:0]   m_req_len,
  output logic [TID_W-1:0]   m_req_tid,
  output logic [BEATS_W-1:0] issue_beats,
  input  logic               xfer
);
  localparam int CNT_W = $clog2(CRED_MAX + 1);
  // compare at the wider of the count and beat widths.
  localparam int CMP_W = (CNT_W > BEATS_W) ? CNT_W : BEATS_W;

  logic [CNT_W-1:0] cred_cnt;
  logic [CNT_W-1:0] cred_free;
  logic             cred_ok;
  logic             issue;

  // cred_cnt holds the beats that are reserved in the card path or the buffer.
  assign cred_free = CNT_W'(CRED_MAX) - cred_cnt;
  assign cred_ok   = (CMP_W'(p_beats) <= CMP_W'(cred_free));

  // the gate is purely combinational on the request path.
  // free credits only grow while a chunk waits, so a raised valid stays up.
  assign m_req_valid = p_valid & cred_ok;
  assign p_ready     = m_req_ready & cred_ok;
  assign issue       = m_req_valid & m_req_ready;

  assign m_req_vaddr = p_vaddr;
  assign m_req_len   = p_len;
  assign m_req_tid   = p_tid;
  assign issue_beats = p_beats;

  // an issue reserves the whole chunk at once; each beat leaving the buffer
  // gives one credit back. Both may land on the same edge.
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cred_cnt <= '0;
    end else begin
      cred_cnt <= cred_cnt + (issue ? CNT_W'(p_beats) : CNT_W'(0)) - CNT_W'(xfer);
    end
  end

endmodule

/* hdl/rd_req_parser.sv */
`timescale 1ns/10ps

module rd_req_parser
  import rd_cred_pkg::*;
#(
  parameter int PMTU = 64
) (
  input  logic               aclk,
  input  logic               rst_n,
  input  logic               q_valid,
  output logic               q_ready,
  input  logic [ADDR_W-1:0]  q_vaddr,
  input  logic [LEN_W-1:0]   q_len,
  input  logic [TID_W-1:0]   q_tid,
  output logic               p_valid,
  input  logic               p_ready,
  output logic [ADDR_W-1:0]  p_vaddr,
  output logic [LEN_W-1:0]   p_len,
  output logic [TID_W-1:0]   p_tid,
  output logic [BEATS_W-1:0] p_beats
);
  // the largest chunk, as a length value.
  localparam logic [LEN_W-1:0] CHUNK_MAX = LEN_W'(PMTU);

  parser_state_t     state;
  logic [ADDR_W-1:0] cur_vaddr;
  logic [LEN_W-1:0]  rem_len;
  logic [TID_W-1:0]  cur_tid;
  logic [LEN_W-1:0]  chunk_len;
  logic              last_chunk;
  logic              chunk_done;

  // ####################
  // chunk selection
  // ####################

  // whatever is left fits in one transfer unit, so this is the final chunk.
  assign last_chunk = (rem_len <= CHUNK_MAX);
  assign chunk_len  = last_chunk ? rem_len : CHUNK_MAX;
  assign chunk_done = p_valid & p_ready;

  // a new request is taken only between requests.
  assign q_ready = (state == PS_IDLE);
  assign p_valid = (state == PS_SPLIT);
  assign p_vaddr = cur_vaddr;
  assign p_len   = chunk_len;
  assign p_tid   = cur_tid;
  // lengths are whole beats, so the division is exact.
  assign p_beats = BEATS_W'(chunk_len / BEAT_BYTES);

  // ####################
  // state and counters
  // ####################

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= PS_IDLE;
      rem_len <= '0;
    end else begin
      case (state)
        PS_IDLE: begin
          if (q_valid) begin
            rem_len <= q_len;
            state   <= PS_SPLIT;
          end
        end
        PS_SPLIT: begin
          if (chunk_done) begin
            rem_len <= rem_len - chunk_len;
            if (last_chunk) state <= PS_IDLE;
          end
        end
        default: state <= PS_IDLE;
      endcase
    end
  end

  // the address moves on by the length of each chunk that was taken.
  always_ff @(posedge aclk) begin
    if (q_valid & q_ready) begin
      cur_vaddr <= q_vaddr;
      cur_tid   <= q_tid;
    end else if (chunk_done) begin
      cur_vaddr <= cur_vaddr + ADDR_W'(chunk_len);
    end
  end

endmodule

/* hdl/rd_req_queue.sv */
`timescale 1ns/10ps

module rd_req_queue
  import rd_cred_pkg::*;
#(
  parameter int QDEPTH = 4
) (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              s_req_valid,
  output logic              s_req_ready,
  input  logic [ADDR_W-1:0] s_req_vaddr,
  input  logic [LEN_W-1:0]  s_req_len,
  input  logic [TID_W-1:0]  s_req_tid,
  output logic              q_valid,
  input  logic              q_ready,
  output logic [ADDR_W-1:0] q_vaddr,
  output logic [LEN_W-1:0]  q_len,
  output logic [TID_W-1:0]  q_tid
);
  localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CNT_W = $clog2(QDEPTH + 1);

  logic [ADDR_W-1:0] mem_vaddr [QDEPTH];
  logic [LEN_W-1:0]  mem_len [QDEPTH];
  logic [TID_W-1:0]  mem_tid [QDEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;

  // the queue refuses new requests only when every slot holds one.
  assign s_req_ready = (count != CNT_W'(QDEPTH));
  assign q_valid     = (count != '0);
  assign push        = s_req_valid & s_req_ready;
  assign pop         = q_valid & q_ready;

  // the head slot is read straight out of the storage registers.
  // a request written on an edge is therefore visible the next cycle.
  assign q_vaddr = mem_vaddr[rd_ptr];
  assign q_len   = mem_len[rd_ptr];
  assign q_tid   = mem_tid[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem_vaddr[wr_ptr] <= s_req_vaddr;
      mem_len[wr_ptr]   <= s_req_len;
      mem_tid[wr_ptr]   <= s_req_tid;
    end
  end

  // pointers wrap at QDEPTH, so the depth need not be a power of two.
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

/* hdl/rd_cred_pkg.sv */
package rd_cred_pkg;

  // ####################
  // widths
  // ####################

  // the virtual address of a read request.
  localparam int ADDR_W = 32;
  // a request or chunk length in bytes.
  localparam int LEN_W = 16;
  // the destination stream id carried with every beat.
  localparam int TID_W = 4;
  // one data beat of the card memory.
  localparam int DATA_W = 64;

  // bytes per data beat, so a length divided by this gives beats.
  localparam int BEAT_BYTES = 8;
  // a beat count drops the three byte-offset bits of a length.
  localparam int BEATS_W = LEN_W - 3;

  // ####################
  // state encodings
  // ####################

  // the parser either waits for a request or is cutting one into chunks.
  typedef enum logic {PS_IDLE, PS_SPLIT} parser_state_t;

  // the tagger is either between chunks or inside a chunk with beats left.
  typedef enum logic {TS_IDLE, TS_STREAM} tagger_state_t;

endpackage
